//--- hw/mem_packet_pkg.sv
package mem_packet_pkg;
    localparam int byte_len       = 8;
    localparam int scratch_words  = 256;
    localparam int request_width  = 64;
    localparam int response_width = 40;

    localparam int req_op_hi   = 63;
    localparam int req_op_lo   = 62;
    localparam int req_tag_hi  = 61;
    localparam int req_tag_lo  = 56;
    localparam int req_addr_hi = 55;
    localparam int req_addr_lo = 48;
    localparam int req_mask_hi = 47;
    localparam int req_mask_lo = 44;
    localparam int req_data_hi = 43;
    localparam int req_data_lo = 12;
    localparam int req_rsvd_hi = 11;
    localparam int req_rsvd_lo = 0;   // must be zero in a legal request.

    localparam int rsp_status_hi = 39;
    localparam int rsp_status_lo = 38;
    localparam int rsp_tag_hi    = 37;
    localparam int rsp_tag_lo    = 32;
    localparam int rsp_data_hi   = 31;
    localparam int rsp_data_lo   = 0;

    typedef logic [request_width-1:0]  request_t;
    typedef logic [response_width-1:0] response_t;
    typedef logic [7:0]                addr_t;
    typedef logic [31:0]               data_t;
    typedef logic [3:0]                mask_t;
    typedef logic [5:0]                tag_t;
endpackage

//--- hw/mem_op_pkg.sv
package mem_op_pkg;
    typedef enum logic [1:0]
    {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_swap  = 2'd2,
        op_bad   = 2'd3    // reserved encoding, always rejected.
    } op_e;

    typedef enum logic [1:0]
    {
        st_ok    = 2'd0,
        st_error = 2'd1
    } status_e;

    typedef enum logic [1:0]
    {
        idle     = 2'd0,
        access   = 2'd1,
        hand_off = 2'd2
    } exec_state_e;

    localparam int request_depth  = 8;
    localparam int response_depth = 4;
endpackage

//--- hw/dual_port_blockram.sv
`timescale 1ns/1ps

module dual_port_blockram
#(
    parameter int    entry_width = 32,
    parameter int    num_set     = 256,
    parameter string config_mode = "WriteFirst"
)
(
    input  logic                                            clk_in,
    input  logic                                            reset_in,

    input  logic                                            port_a_access_en,
    input  logic [entry_width/mem_packet_pkg::byte_len-1:0] port_a_write_en,
    input  logic [$clog2(num_set)-1:0]                      port_a_addr,
    input  logic [entry_width-1:0]                          port_a_write_entry,
    output logic [entry_width-1:0]                          port_a_read_entry,

    input  logic                                            port_b_access_en,
    input  logic [entry_width/mem_packet_pkg::byte_len-1:0] port_b_write_en,
    input  logic [$clog2(num_set)-1:0]                      port_b_addr,
    input  logic [entry_width-1:0]                          port_b_write_entry,
    output logic [entry_width-1:0]                          port_b_read_entry
);
    localparam int byte_bits   = mem_packet_pkg::byte_len;
    localparam int mask_len    = entry_width / byte_bits;
    localparam bit write_first = (config_mode == "WriteFirst");

    logic [entry_width-1:0] mem [num_set];
    logic [entry_width-1:0] merged_a;
    logic [entry_width-1:0] merged_b;

    function automatic logic [entry_width-1:0] merge_bytes
    (
        input logic [entry_width-1:0] old_word,
        input logic [entry_width-1:0] new_word,
        input logic [mask_len-1:0]    byte_en
    );
        logic [entry_width-1:0] word;
        word = old_word;
        for (int b = 0; b < mask_len; b++)
        begin
            if (byte_en[b])
                word[b*byte_bits +: byte_bits] = new_word[b*byte_bits +: byte_bits];
        end
        return word;
    endfunction

    assign merged_a = merge_bytes(mem[port_a_addr], port_a_write_entry, port_a_write_en);
    assign merged_b = merge_bytes(mem[port_b_addr], port_b_write_entry, port_b_write_en);

    always_ff @(posedge clk_in)
    begin
        if (port_a_access_en && |port_a_write_en)
            mem[port_a_addr] <= merged_a;
        if (port_b_access_en && |port_b_write_en)
            mem[port_b_addr] <= merged_b;   // port b wins a same-address collision.
    end

    // a port sees the other port's write to the same word only one cycle later.
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            port_a_read_entry <= '0;
            port_b_read_entry <= '0;
        end
        else
        begin
            if (port_a_access_en)
                port_a_read_entry <= write_first ? merged_a : mem[port_a_addr];
            if (port_b_access_en)
                port_b_read_entry <= write_first ? merged_b : mem[port_b_addr];
        end
    end
endmodule

//--- hw/fifo_queue.sv
`timescale 1ns/1ps

module fifo_queue
#(
    parameter int    entry_width  = 64,
    parameter int    queue_size   = 8,
    parameter string storage_type = "BlockRAM"   // FlipFlop or BlockRAM.
)
(
    input  logic                   clk_in,
    input  logic                   reset_in,

    output logic                   is_empty_out,
    output logic                   is_full_out,

    input  logic [entry_width-1:0] request_in,
    input  logic                   request_valid_in,
    output logic                   issue_ack_out,

    output logic [entry_width-1:0] request_out,
    output logic                   request_valid_out,
    input  logic                   issue_ack_in
);
    localparam int ptr_width = $clog2(queue_size);

    logic [ptr_width-1:0]  write_ptr;
    logic [ptr_width-1:0]  read_ptr;
    logic [ptr_width-1:0]  read_ptr_next;
    logic [queue_size-1:0] entry_valid;
    logic [queue_size-1:0] entry_valid_next;
    logic                  write_ok;
    logic                  pop;

    function automatic logic [ptr_width-1:0] advance(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(queue_size - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign is_full_out  = &entry_valid;
    assign is_empty_out = ~|entry_valid;

    assign pop = issue_ack_in && entry_valid[read_ptr];

    // a full queue still takes a write when the head leaves in the same cycle.
    assign write_ok = request_valid_in && !issue_ack_out && (!is_full_out || pop);

    assign read_ptr_next = pop ? advance(read_ptr) : read_ptr;

    always_comb
    begin
        entry_valid_next = entry_valid;
        if (pop)
            entry_valid_next[read_ptr] = 1'b0;
        if (write_ok)
            entry_valid_next[write_ptr] = 1'b1;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            write_ptr         <= '0;
            read_ptr          <= '0;
            entry_valid       <= '0;
            issue_ack_out     <= 1'b0;
            request_valid_out <= 1'b0;
        end
        else
        begin
            if (write_ok)
                write_ptr <= advance(write_ptr);
            read_ptr          <= read_ptr_next;
            entry_valid       <= entry_valid_next;
            issue_ack_out     <= write_ok;
            request_valid_out <= entry_valid_next[read_ptr_next];   // tracks the head slot.
        end
    end

    generate
        if (storage_type == "FlipFlop")
        begin : g_flops
            logic [entry_width-1:0] entries [queue_size];

            always_ff @(posedge clk_in)
            begin
                if (write_ok)
                    entries[write_ptr] <= request_in;
                if (write_ok && write_ptr == read_ptr_next)
                    request_out <= request_in;   // empty head takes the incoming entry.
                else
                    request_out <= entries[read_ptr_next];
            end
        end
        else
        begin : g_bram
            localparam int mask_len = entry_width / mem_packet_pkg::byte_len;

            logic [entry_width-1:0] ram_word;
            logic [entry_width-1:0] bypass_word;
            logic                   bypass_hit;

            // port b always reads the slot that is the head in the next cycle.
            dual_port_blockram
            #(
                .entry_width        (entry_width),
                .num_set            (queue_size),
                .config_mode        ("WriteFirst")
            )
            storage
            (
                .clk_in             (clk_in),
                .reset_in           (reset_in),

                .port_a_access_en   (write_ok),
                .port_a_write_en    ({mask_len{write_ok}}),
                .port_a_addr        (write_ptr),
                .port_a_write_entry (request_in),
                .port_a_read_entry  (),

                .port_b_access_en   (1'b1),
                .port_b_write_en    ({mask_len{1'b0}}),
                .port_b_addr        (read_ptr_next),
                .port_b_write_entry ({entry_width{1'b0}}),
                .port_b_read_entry  (ram_word)
            );

            always_ff @(posedge clk_in)
            begin
                if (reset_in)
                    bypass_hit <= 1'b0;
                else
                    bypass_hit <= write_ok && write_ptr == read_ptr_next;
            end

            always_ff @(posedge clk_in)
            begin
                bypass_word <= request_in;
            end

            assign request_out = bypass_hit ? bypass_word : ram_word;   // port b misses a same-cycle write.
        end
    endgenerate
endmodule

//--- hw/request_decoder.sv
`timescale 1ns/1ps

module request_decoder
(
    input  mem_packet_pkg::request_t entry,
    input  logic                     entry_valid,
    output mem_op_pkg::op_e          op,
    output mem_packet_pkg::tag_t     tag,
    output mem_packet_pkg::addr_t    addr,
    output mem_packet_pkg::data_t    data,
    output mem_packet_pkg::mask_t    mask,
    output logic                     legal
);
    logic reserved_clear;
    logic mask_ok;

    assign op = mem_op_pkg::op_e'(
        entry[mem_packet_pkg::req_op_hi:mem_packet_pkg::req_op_lo]);

    assign tag  = entry[mem_packet_pkg::req_tag_hi:mem_packet_pkg::req_tag_lo];
    assign addr = entry[mem_packet_pkg::req_addr_hi:mem_packet_pkg::req_addr_lo];
    assign data = entry[mem_packet_pkg::req_data_hi:mem_packet_pkg::req_data_lo];
    assign mask = entry[mem_packet_pkg::req_mask_hi:mem_packet_pkg::req_mask_lo];

    assign reserved_clear =
        entry[mem_packet_pkg::req_rsvd_hi:mem_packet_pkg::req_rsvd_lo] == '0;

    // only a read may carry an empty mask.
    assign mask_ok = (op == mem_op_pkg::op_read) || (mask != '0);

    assign legal = entry_valid
                   && (op != mem_op_pkg::op_bad)
                   && reserved_clear
                   && mask_ok;
endmodule

//--- hw/request_executor.sv
`timescale 1ns/1ps

module request_executor
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    input  logic                  head_valid,
    input  mem_op_pkg::op_e       op,
    input  mem_packet_pkg::tag_t  tag,
    input  mem_packet_pkg::addr_t addr,
    input  mem_packet_pkg::data_t data,
    input  mem_packet_pkg::mask_t mask,
    input  logic                  legal,
    output logic                  pop,

    output logic                  ram_en,
    output mem_packet_pkg::mask_t ram_write_en,
    output mem_packet_pkg::addr_t ram_addr,
    output mem_packet_pkg::data_t ram_write_data,
    input  mem_packet_pkg::data_t ram_read_data,

    input  logic                  builder_busy,
    output logic                  result_valid,
    output mem_op_pkg::status_e   result_status,
    output mem_packet_pkg::tag_t  result_tag,
    output mem_packet_pkg::data_t result_data
);
    mem_op_pkg::exec_state_e state;
    mem_op_pkg::exec_state_e state_next;
    logic                    is_store;

    assign is_store = (op == mem_op_pkg::op_write) || (op == mem_op_pkg::op_swap);

    always_comb
    begin
        state_next = state;
        case (state)
            mem_op_pkg::idle:
                if (head_valid && !builder_busy)
                    state_next = mem_op_pkg::access;
            mem_op_pkg::access:
                state_next = mem_op_pkg::hand_off;
            default:
                state_next = mem_op_pkg::idle;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
            state <= mem_op_pkg::idle;
        else
            state <= state_next;
    end

    // the ram runs read-first, so a swap gets the old word back from this access.
    assign ram_en         = (state == mem_op_pkg::access) && legal;
    assign ram_write_en   = (ram_en && is_store) ? mask : '0;
    assign ram_addr       = addr;
    assign ram_write_data = data;

    // the head stays in place until this pop, so the decoded fields hold throughout.
    assign pop           = (state == mem_op_pkg::hand_off);
    assign result_valid  = pop;
    assign result_status = legal ? mem_op_pkg::st_ok : mem_op_pkg::st_error;
    assign result_tag    = tag;
    assign result_data   = (legal && op != mem_op_pkg::op_write) ? ram_read_data : '0;
endmodule

//--- hw/response_builder.sv
`timescale 1ns/1ps

module response_builder
(
    input  logic                      clk_in,
    input  logic                      reset_in,

    input  logic                      result_valid,
    input  mem_op_pkg::status_e       result_status,
    input  mem_packet_pkg::tag_t      result_tag,
    input  mem_packet_pkg::data_t     result_data,
    output logic                      busy,

    output mem_packet_pkg::response_t response_entry,
    output logic                      response_valid,
    input  logic                      response_ack
);
    mem_packet_pkg::response_t packed_result;

    always_comb
    begin
        packed_result[mem_packet_pkg::rsp_status_hi:mem_packet_pkg::rsp_status_lo] =
            result_status;
        packed_result[mem_packet_pkg::rsp_tag_hi:mem_packet_pkg::rsp_tag_lo] = result_tag;
        packed_result[mem_packet_pkg::rsp_data_hi:mem_packet_pkg::rsp_data_lo] = result_data;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
            response_valid <= 1'b0;
        else if (result_valid)
            response_valid <= 1'b1;
        else if (response_ack)
            response_valid <= 1'b0;   // the response queue has taken it.
    end

    always_ff @(posedge clk_in)
    begin
        if (result_valid)
            response_entry <= packed_result;
    end

    assign busy = response_valid;   // the executor waits until the slot is free again.
endmodule

//--- hw/mem_request_unit.sv
`timescale 1ns/1ps

module mem_request_unit
(
    input  logic                      clk_in,
    input  logic                      reset_in,

    input  mem_packet_pkg::request_t  request_in,
    input  logic                      request_valid_in,
    output logic                      request_ack,

    output mem_packet_pkg::response_t response_out,
    output logic                      response_valid_out,
    input  logic                      response_ack_in
);
    mem_packet_pkg::request_t  head_entry;
    logic                      head_valid;
    logic                      pop;
    mem_op_pkg::op_e           op;
    mem_packet_pkg::tag_t      tag;
    mem_packet_pkg::addr_t     addr;
    mem_packet_pkg::data_t     data;
    mem_packet_pkg::mask_t     mask;
    logic                      legal;
    logic                      ram_en;
    mem_packet_pkg::mask_t     ram_write_en;
    mem_packet_pkg::addr_t     ram_addr;
    mem_packet_pkg::data_t     ram_write_data;
    mem_packet_pkg::data_t     ram_read_data;
    logic                      result_valid;
    mem_op_pkg::status_e       result_status;
    mem_packet_pkg::tag_t      result_tag;
    mem_packet_pkg::data_t     result_data;
    logic                      builder_busy;
    mem_packet_pkg::response_t built_response;
    logic                      built_valid;
    logic                      built_ack;

    fifo_queue
    #(
        .entry_width  ($bits(mem_packet_pkg::request_t)),
        .queue_size   (mem_op_pkg::request_depth),
        .storage_type ("BlockRAM")
    )
    request_queue
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .is_empty_out      (),
        .is_full_out       (),
        .request_in        (request_in),
        .request_valid_in  (request_valid_in),
        .issue_ack_out     (request_ack),
        .request_out       (head_entry),
        .request_valid_out (head_valid),
        .issue_ack_in      (pop)
    );

    request_decoder decoder
    (
        .entry       (head_entry),
        .entry_valid (head_valid),
        .op          (op),
        .tag         (tag),
        .addr        (addr),
        .data        (data),
        .mask        (mask),
        .legal       (legal)
    );

    request_executor executor
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .head_valid     (head_valid),
        .op             (op),
        .tag            (tag),
        .addr           (addr),
        .data           (data),
        .mask           (mask),
        .legal          (legal),
        .pop            (pop),
        .ram_en         (ram_en),
        .ram_write_en   (ram_write_en),
        .ram_addr       (ram_addr),
        .ram_write_data (ram_write_data),
        .ram_read_data  (ram_read_data),
        .builder_busy   (builder_busy),
        .result_valid   (result_valid),
        .result_status  (result_status),
        .result_tag     (result_tag),
        .result_data    (result_data)
    );

    dual_port_blockram
    #(
        .entry_width (mem_packet_pkg::byte_len * $bits(mem_packet_pkg::mask_t)),
        .num_set     (mem_packet_pkg::scratch_words),
        .config_mode ("ReadFirst")
    )
    scratch_ram
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .port_a_access_en   (ram_en),
        .port_a_write_en    (ram_write_en),
        .port_a_addr        (ram_addr),
        .port_a_write_entry (ram_write_data),
        .port_a_read_entry  (ram_read_data),
        .port_b_access_en   (1'b0),
        .port_b_write_en    ('0),
        .port_b_addr        ('0),
        .port_b_write_entry ('0),
        .port_b_read_entry  ()
    );

    response_builder builder
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .result_valid   (result_valid),
        .result_status  (result_status),
        .result_tag     (result_tag),
        .result_data    (result_data),
        .busy           (builder_busy),
        .response_entry (built_response),
        .response_valid (built_valid),
        .response_ack   (built_ack)
    );

    fifo_queue
    #(
        .entry_width  ($bits(mem_packet_pkg::response_t)),
        .queue_size   (mem_op_pkg::response_depth),
        .storage_type ("FlipFlop")
    )
    response_queue
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .is_empty_out      (),
        .is_full_out       (),
        .request_in        (built_response),
        .request_valid_in  (built_valid),
        .issue_ack_out     (built_ack),
        .request_out       (response_out),
        .request_valid_out (response_valid_out),
        .issue_ack_in      (response_ack_in)
    );
endmodule

//--- test/mem_request_unit_chk.sv
`timescale 1ns/1ps

module mem_request_unit_chk
(
    input logic                      clk_in,
    input logic                      reset_in,
    input mem_packet_pkg::request_t  request_in,
    input logic                      request_valid_in,
    input logic                      request_ack,
    input mem_packet_pkg::response_t built_response,
    input logic                      built_valid,
    input logic                      built_ack,
    input mem_packet_pkg::response_t response_out,
    input logic                      response_valid_out,
    input logic                      response_ack_in
);
    int assert_failures = 0;

    // a producer may change its item only in the cycle after the ack pulse.
    assert property (@(posedge clk_in) disable iff (reset_in)
        request_valid_in && !request_ack && $past(request_valid_in) |-> $stable(request_in))
    else
    begin
        $error("request_in changed while waiting for request_ack");
        assert_failures++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        built_valid && !built_ack && $past(built_valid) |-> $stable(built_response))
    else
    begin
        $error("builder response changed while waiting for the response queue");
        assert_failures++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        response_valid_out && !response_ack_in |=> response_valid_out && $stable(response_out))
    else
    begin
        $error("response_out changed or vanished without response_ack_in");
        assert_failures++;
    end

    assert property (@(posedge clk_in) disable iff (reset_in)
        (!request_ack || $past(request_valid_in)) && (!built_ack || $past(built_valid)))
    else
    begin
        $error("a queue acknowledged an item that was never offered");
        assert_failures++;
    end

    assert property (@(posedge clk_in) reset_in |=> !response_valid_out)
    else
    begin
        $error("response_valid_out is high during reset");
        assert_failures++;
    end
endmodule

bind mem_request_unit mem_request_unit_chk chk
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .request_in         (request_in),
    .request_valid_in   (request_valid_in),
    .request_ack        (request_ack),
    .built_response     (built_response),
    .built_valid        (built_valid),
    .built_ack          (built_ack),
    .response_out       (response_out),
    .response_valid_out (response_valid_out),
    .response_ack_in    (response_ack_in)
);

//--- test/mem_request_unit_tb.sv
`timescale 1ns/1ps

module mem_request_unit_tb;
    localparam int reset_cycles   = 10;
    localparam int cycles_per_req = 200;
    localparam int ack_wait       = 40;
    localparam int backlog_limit  = 16;
    localparam int random_count   = 40;
    localparam int directed_count = 11;   // requests sent by the four directed tests.
    localparam int total_requests =
        mem_packet_pkg::scratch_words + directed_count + backlog_limit + random_count;

    logic                      clk_in;
    logic                      reset_in;
    mem_packet_pkg::request_t  request_in;
    logic                      request_valid_in;
    logic                      request_ack;
    mem_packet_pkg::response_t response_out;
    logic                      response_valid_out;
    logic                      response_ack_in;

    mem_packet_pkg::data_t     model_mem [mem_packet_pkg::scratch_words];
    mem_packet_pkg::response_t expected_q [$];
    mem_packet_pkg::tag_t      next_tag;
    integer                    seed;

    mem_request_unit dut
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .request_in         (request_in),
        .request_valid_in   (request_valid_in),
        .request_ack        (request_ack),
        .response_out       (response_out),
        .response_valid_out (response_valid_out),
        .response_ack_in    (response_ack_in)
    );

    always #2 clk_in = ~clk_in;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_value
    (
        input string       name,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        if (actual !== expected)
            abort_run($sformatf("ERROR at %0d ns: %s expected 0x%0h, got 0x%0h",
                                $time, name, expected, actual));
    endtask

    function automatic mem_packet_pkg::data_t fill_word(input int addr);
        return {8'(addr), 8'(~addr), 8'(addr * 7 + 13), 8'(addr ^ 'h5a)};
    endfunction

    // expected response and memory update, taken from the request rules.
    task automatic predict(input mem_packet_pkg::request_t pkt);
        logic [1:0]            op;
        mem_packet_pkg::tag_t  tag;
        mem_packet_pkg::addr_t addr;
        mem_packet_pkg::mask_t mask;
        mem_packet_pkg::data_t data;
        logic [11:0]           rsvd;
        mem_packet_pkg::data_t merged;
        logic                  legal;
        {op, tag, addr, mask, data, rsvd} = pkt;
        legal = (op != mem_op_pkg::op_bad) && (rsvd == '0)
                && (op == mem_op_pkg::op_read || mask != '0);
        merged = model_mem[addr];
        for (int b = 0; b < 4; b++)
        begin
            if (mask[b])
                merged[8*b +: 8] = data[8*b +: 8];
        end
        if (!legal)
            expected_q.push_back({2'(mem_op_pkg::st_error), tag, 32'h0});
        else if (op == mem_op_pkg::op_read)
            expected_q.push_back({2'(mem_op_pkg::st_ok), tag, model_mem[addr]});
        else
        begin
            expected_q.push_back({2'(mem_op_pkg::st_ok), tag,
                                  (op == mem_op_pkg::op_swap) ? model_mem[addr] : 32'h0});
            model_mem[addr] = merged;
        end
    endtask

    task automatic try_send
    (
        input  logic [1:0]            op,
        input  mem_packet_pkg::addr_t addr,
        input  mem_packet_pkg::mask_t mask,
        input  mem_packet_pkg::data_t data,
        input  logic [11:0]           rsvd,
        output bit                    accepted
    );
        mem_packet_pkg::request_t pkt;
        int                       waited;
        pkt = {op, next_tag, addr, mask, data, rsvd};
        next_tag++;
        request_in = pkt;
        request_valid_in = 1'b1;
        accepted = 1'b0;
        waited = 0;
        while (!accepted && waited < ack_wait)
        begin
            @(posedge clk_in);
            #1;
            accepted = (request_ack === 1'b1);
            waited++;
        end
        request_valid_in = 1'b0;
        if (accepted)
            predict(pkt);
    endtask

    task automatic send_request
    (
        input logic [1:0]            op,
        input mem_packet_pkg::addr_t addr,
        input mem_packet_pkg::mask_t mask,
        input mem_packet_pkg::data_t data,
        input logic [11:0]           rsvd
    );
        bit accepted;
        try_send(op, addr, mask, data, rsvd, accepted);
        if (!accepted)
            abort_run("request_ack did not arrive within the allowed number of cycles");
    endtask

    task automatic expect_response();
        mem_packet_pkg::response_t actual;
        logic [1:0]                exp_status;
        logic [1:0]                act_status;
        mem_packet_pkg::tag_t      exp_tag;
        mem_packet_pkg::tag_t      act_tag;
        mem_packet_pkg::data_t     exp_data;
        mem_packet_pkg::data_t     act_data;
        response_ack_in = 1'b1;
        while (response_valid_out !== 1'b1)
        begin
            @(posedge clk_in);
            #1;
        end
        actual = response_out;
        @(posedge clk_in);   // the pop happens on this edge.
        #1;
        response_ack_in = 1'b0;
        if (expected_q.size() == 0)
            abort_run("a response arrived with no request outstanding");
        else
        begin
            {exp_status, exp_tag, exp_data} = expected_q.pop_front();
            {act_status, act_tag, act_data} = actual;
            check_value("response status", exp_status, act_status);
            check_value("response tag", exp_tag, act_tag);
            check_value("response data", exp_data, act_data);
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < mem_packet_pkg::scratch_words; a++)
        begin
            send_request(mem_op_pkg::op_write, 8'(a), 4'hf, fill_word(a), 12'h0);
            expect_response();
        end
    endtask

    task automatic write_then_read();
        send_request(mem_op_pkg::op_write, 8'h21, 4'hf, 32'hdead_beef, 12'h0);
        expect_response();
        send_request(mem_op_pkg::op_read, 8'h21, 4'h0, 32'h0, 12'h0);
        expect_response();
    endtask

    task automatic masked_write();
        send_request(mem_op_pkg::op_write, 8'h42, 4'b0101, 32'h1122_3344, 12'h0);
        expect_response();
        send_request(mem_op_pkg::op_write, 8'h42, 4'b1000, 32'hff00_0000, 12'h0);
        expect_response();
        send_request(mem_op_pkg::op_read, 8'h42, 4'h0, 32'h0, 12'h0);
        expect_response();
    endtask

    task automatic swap_word();
        send_request(mem_op_pkg::op_swap, 8'h7f, 4'b0110, 32'hcafe_f00d, 12'h0);
        expect_response();
        send_request(mem_op_pkg::op_read, 8'h7f, 4'h0, 32'h0, 12'h0);
        expect_response();
    endtask

    task automatic illegal_requests();
        send_request(mem_op_pkg::op_bad, 8'h10, 4'hf, 32'h1234_5678, 12'h0);
        expect_response();
        send_request(mem_op_pkg::op_write, 8'h10, 4'hf, 32'h1234_5678, 12'h801);
        expect_response();
        send_request(mem_op_pkg::op_write, 8'h10, 4'h0, 32'h1234_5678, 12'h0);
        expect_response();
        send_request(mem_op_pkg::op_read, 8'h10, 4'h0, 32'h0, 12'h0);
        expect_response();
    endtask

    task automatic back_pressure();
        bit accepted;
        int count;
        count = 0;
        accepted = 1'b1;
        while (accepted && count < backlog_limit)
        begin
            if (count % 2 == 0)
                try_send(mem_op_pkg::op_write, 8'(8'h90 + count / 2), 4'hf,
                         32'ha5a5_0000 + count, 12'h0, accepted);
            else
                try_send(mem_op_pkg::op_read, 8'(8'h90 + count / 2), 4'h0, 32'h0,
                         12'h0, accepted);
            if (accepted)
                count++;
        end
        // both queues and the builder's slot are full when the acks stop.
        check_value("accepted requests",
                    mem_op_pkg::request_depth + mem_op_pkg::response_depth + 1, count);
        repeat (count) expect_response();
    endtask

    task automatic random_traffic();
        logic [1:0]            op;
        mem_packet_pkg::addr_t addr;
        mem_packet_pkg::mask_t mask;
        mem_packet_pkg::data_t data;
        fork
            begin
                for (int n = 0; n < random_count; n++)
                begin
                    op   = 2'($unsigned($random(seed)) % 3);
                    addr = 8'($random(seed));
                    mask = 4'($random(seed));
                    data = $random(seed);
                    if (mask == '0)
                        mask = 4'hf;   // keeps every random write and swap legal.
                    send_request(op, addr, mask, data, 12'h0);
                end
            end
            repeat (random_count) expect_response();
        join
    endtask

    initial
    begin
        repeat (reset_cycles + cycles_per_req * total_requests) @(posedge clk_in);
        abort_run("the run timed out before all tests finished");
    end

    initial
    begin
        wait (dut.chk.assert_failures != 0);
        abort_run("a handshake assertion in the bound checker failed");
    end

    initial
    begin
        clk_in = 1'b0;
        reset_in = 1'b1;
        request_in = '0;
        request_valid_in = 1'b0;
        response_ack_in = 1'b0;
        next_tag = '0;
        seed = 32'he528c807;
        repeat (reset_cycles) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        fill_memory();
        write_then_read();
        masked_write();
        swap_word();
        illegal_requests();
        back_pressure();
        random_traffic();
        if (dut.chk.assert_failures == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
            abort_run("the bound handshake checker reported a failed assertion");
    end
endmodule

//--- mem_request_unit.f
hw/mem_packet_pkg.sv
hw/mem_op_pkg.sv
hw/dual_port_blockram.sv
hw/fifo_queue.sv
hw/request_decoder.sv
hw/request_executor.sv
hw/response_builder.sv
hw/mem_request_unit.sv
test/mem_request_unit_chk.sv
test/mem_request_unit_tb.sv
